//--- vrf_defs.svh
`ifndef VRF_DEFS_SVH
`define VRF_DEFS_SVH

// lanes working side by side on one vector
`define V_LANES 4

// vector length in bits
`define VLEN 256

// element width in bits
`define ELEN 32

// architectural vector registers
`define VREGS 32

// words held by one lane
// 32 regs * 256 bits / (32 bits * 4 lanes) = 64
`define VRF_DEPTH ((`VREGS * `VLEN) / (`ELEN * `V_LANES))

// write ports per lane
`define VRF_WPORTS 2

// read ports per lane
`define VRF_RPORTS 4

`endif

//--- vrf_pkg.sv
`default_nettype none

`include "vrf_defs.svh"

package vrf_pkg;

   // one element of one lane
   typedef logic [`ELEN-1:0] vrf_elem_t;

   // word address inside a lane
   // upper bits pick the vector register, low bit the element row
   typedef logic [$clog2(`VRF_DEPTH)-1:0] vrf_addr_t;

   // one bit per lane
   typedef logic [`V_LANES-1:0] vrf_lane_mask_t;

   // index of a write port, as kept in the LVT
   typedef logic [$clog2(`VRF_WPORTS)-1:0] vrf_wsel_t;

endpackage : vrf_pkg

`default_nettype wire

//--- vrf_bank_ram.sv
`default_nettype none

`include "vrf_defs.svh"

// one write port, one read port, registered read
module vrf_bank_ram
   import vrf_pkg::*;
(
   input  wire             clk,
   input  wire             we,
   input  wire vrf_addr_t  waddr,
   input  wire vrf_elem_t  wdata,
   input  wire vrf_addr_t  raddr,
   output vrf_elem_t       rdata
);

   vrf_elem_t mem [`VRF_DEPTH];

   // write side
   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[waddr] <= wdata;
      end
   end

   // read side samples the array before this edge's write lands,
   // so a colliding read sees the old word
   always_ff @(posedge clk)
   begin
      rdata <= mem[raddr];
   end

endmodule : vrf_bank_ram

`default_nettype wire

//--- vrf_lvt.sv
`default_nettype none

`include "vrf_defs.svh"

// live value table for a 2-write, 4-read memory
module vrf_lvt
   import vrf_pkg::*;
(
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire logic [`VRF_WPORTS-1:0]        we,
   input  wire vrf_addr_t [`VRF_WPORTS-1:0]   waddr,
   input  wire vrf_addr_t [`VRF_RPORTS-1:0]   raddr,
   output vrf_wsel_t [`VRF_RPORTS-1:0]        rsel
);

   // last writing port per address
   vrf_wsel_t lvt_q [`VRF_DEPTH];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < `VRF_DEPTH; i++)
         begin
            lvt_q[i] <= '0;
         end
      end
      else
      begin
         // higher port comes last in the loop and so wins a collision
         for (int w = 0; w < `VRF_WPORTS; w++)
         begin
            if (we[w])
            begin
               lvt_q[waddr[w]] <= vrf_wsel_t'(w);
            end
         end
      end
   end

   // lookup is registered to line up with the bank read data
   // old table entry on a same-cycle write, same as the banks
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rsel <= '0;
      end
      else
      begin
         for (int r = 0; r < `VRF_RPORTS; r++)
         begin
            rsel[r] <= lvt_q[raddr[r]];
         end
      end
   end

endmodule : vrf_lvt

`default_nettype wire

//--- vrf_lane.sv
`default_nettype none

`include "vrf_defs.svh"

// one lane of the register file
// 2 write ports x 4 read ports, each write port owns a bank of
// four read copies, the LVT says which bank is live per address
module vrf_lane
   import vrf_pkg::*;
(
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire logic [`VRF_WPORTS-1:0]        wr_en,
   input  wire vrf_addr_t [`VRF_WPORTS-1:0]   wr_addr,
   input  wire vrf_elem_t [`VRF_WPORTS-1:0]   wr_data,
   input  wire vrf_addr_t [`VRF_RPORTS-1:0]   rd_addr,
   output vrf_elem_t [`VRF_RPORTS-1:0]        rd_data
);

   // read data of every copy, by write bank then read port
   vrf_elem_t bank_rdata [`VRF_WPORTS][`VRF_RPORTS];

   // live bank per read port, one cycle after the address
   vrf_wsel_t [`VRF_RPORTS-1:0] rsel;

   for (genvar w = 0; w < `VRF_WPORTS; w++)
   begin : g_wbank
      for (genvar r = 0; r < `VRF_RPORTS; r++)
      begin : g_rcopy
         // every copy of bank w takes the same writes
         vrf_bank_ram bank_i
         (
            .clk   (clk),
            .we    (wr_en[w]),
            .waddr (wr_addr[w]),
            .wdata (wr_data[w]),
            .raddr (rd_addr[r]),
            .rdata (bank_rdata[w][r])
         );
      end
   end

   vrf_lvt lvt_i
   (
      .clk   (clk),
      .rst_n (rst_n),
      .we    (wr_en),
      .waddr (wr_addr),
      .raddr (rd_addr),
      .rsel  (rsel)
   );

   // pick the live bank for each reader
   always_comb
   begin
      for (int r = 0; r < `VRF_RPORTS; r++)
      begin
         rd_data[r] = bank_rdata[rsel[r]][r];
      end
   end

endmodule : vrf_lane

`default_nettype wire

//--- vrf_top.sv
`default_nettype none

`include "vrf_defs.svh"

// vector register file, V_LANES lanes on shared addresses
module vrf_top
   import vrf_pkg::*;
(
   input  wire                                clk,
   input  wire                                rst_n,

   input  wire                                wr_en_0,
   input  wire vrf_addr_t                     wr_addr_0,
   input  wire vrf_lane_mask_t                wr_mask_0,
   input  wire vrf_elem_t [`V_LANES-1:0]      wr_data_0,

   input  wire                                wr_en_1,
   input  wire vrf_addr_t                     wr_addr_1,
   input  wire vrf_lane_mask_t                wr_mask_1,
   input  wire vrf_elem_t [`V_LANES-1:0]      wr_data_1,

   input  wire                                rd_en_0,
   input  wire vrf_addr_t                     rd_addr_0,
   input  wire                                rd_en_1,
   input  wire vrf_addr_t                     rd_addr_1,
   input  wire                                rd_en_2,
   input  wire vrf_addr_t                     rd_addr_2,
   input  wire                                rd_en_3,
   input  wire vrf_addr_t                     rd_addr_3,

   output wire                                rd_valid_0,
   output wire                                rd_valid_1,
   output wire                                rd_valid_2,
   output wire                                rd_valid_3,
   output wire vrf_elem_t [`V_LANES-1:0]      rd_data_0,
   output wire vrf_elem_t [`V_LANES-1:0]      rd_data_1,
   output wire vrf_elem_t [`V_LANES-1:0]      rd_data_2,
   output wire vrf_elem_t [`V_LANES-1:0]      rd_data_3
);

   vrf_addr_t [`VRF_WPORTS-1:0] wr_addr;
   vrf_addr_t [`VRF_RPORTS-1:0] rd_addr;
   logic [`VRF_RPORTS-1:0]      rd_en;
   logic [`VRF_RPORTS-1:0]      rd_valid_q;

   assign wr_addr = {wr_addr_1, wr_addr_0};
   assign rd_addr = {rd_addr_3, rd_addr_2, rd_addr_1, rd_addr_0};
   assign rd_en   = {rd_en_3, rd_en_2, rd_en_1, rd_en_0};

   // data is out of the banks one clock after the request
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rd_valid_q <= '0;
      end
      else
      begin
         rd_valid_q <= rd_en;
      end
   end

   assign rd_valid_0 = rd_valid_q[0];
   assign rd_valid_1 = rd_valid_q[1];
   assign rd_valid_2 = rd_valid_q[2];
   assign rd_valid_3 = rd_valid_q[3];

   for (genvar l = 0; l < `V_LANES; l++)
   begin : g_lane
      logic [`VRF_WPORTS-1:0]      lane_wr_en;
      vrf_elem_t [`VRF_WPORTS-1:0] lane_wr_data;
      vrf_elem_t [`VRF_RPORTS-1:0] lane_rd_data;

      // masked-off lanes see no write strobe
      assign lane_wr_en   = {wr_en_1 & wr_mask_1[l], wr_en_0 & wr_mask_0[l]};
      assign lane_wr_data = {wr_data_1[l], wr_data_0[l]};

      vrf_lane lane_i
      (
         .clk     (clk),
         .rst_n   (rst_n),
         .wr_en   (lane_wr_en),
         .wr_addr (wr_addr),
         .wr_data (lane_wr_data),
         .rd_addr (rd_addr),
         .rd_data (lane_rd_data)
      );

      assign rd_data_0[l] = lane_rd_data[0];
      assign rd_data_1[l] = lane_rd_data[1];
      assign rd_data_2[l] = lane_rd_data[2];
      assign rd_data_3[l] = lane_rd_data[3];
   end

endmodule : vrf_top

`default_nettype wire

//--- vrf_props.sv
`default_nettype none

`include "vrf_defs.svh"

// read strobe timing at the register file top
module vrf_props
(
   input wire                     clk,
   input wire                     rst_n,
   input wire [`VRF_RPORTS-1:0]   rd_en,
   input wire [`VRF_RPORTS-1:0]   rd_valid
);

   timeunit 1ns;
   timeprecision 100ps;

   // valid is the request delayed by one clock
   a_valid_follows_en: assert property (
      @(posedge clk) disable iff (!rst_n)
      rd_valid == $past(rd_en))
   else $error("rd_valid does not follow rd_en by one cycle");

   // nothing comes out while reset is held
   a_no_valid_in_reset: assert property (
      @(posedge clk)
      !rst_n |-> rd_valid == '0)
   else $error("rd_valid high during reset");

   a_valid_known: assert property (
      @(posedge clk) disable iff (!rst_n)
      !$isunknown(rd_valid))
   else $error("rd_valid unknown after reset");

endmodule : vrf_props

bind vrf_top vrf_props vrf_props_i
(
   .clk      (clk),
   .rst_n    (rst_n),
   .rd_en    (rd_en),
   .rd_valid (rd_valid_q)
);

`default_nettype wire

//--- vrf_tb.sv
`default_nettype none

`include "vrf_defs.svh"

// testbench for the vector register file
module vrf_tb
   import vrf_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int MIX_CYCLES    = 2000;
   localparam int RUN_LIMIT_NS  = 50000;

   logic clk = 1'b0;
   logic rst_n;

   logic                              wr_en_v   [`VRF_WPORTS];
   vrf_addr_t                         wr_addr_v [`VRF_WPORTS];
   vrf_lane_mask_t                    wr_mask_v [`VRF_WPORTS];
   vrf_elem_t [`V_LANES-1:0]          wr_data_v [`VRF_WPORTS];
   logic                              rd_en_v   [`VRF_RPORTS];
   vrf_addr_t                         rd_addr_v [`VRF_RPORTS];
   logic                              rd_valid_v [`VRF_RPORTS];
   vrf_elem_t [`V_LANES-1:0]          rd_data_v [`VRF_RPORTS];

   // reference contents, lane by address
   vrf_elem_t model_mem [`V_LANES][`VRF_DEPTH];

   // expected results of the reads issued in the current cycle
   logic      exp_valid [`VRF_RPORTS];
   vrf_elem_t exp_data  [`VRF_RPORTS][`V_LANES];

   integer seed;

   always #2 clk = ~clk;

   vrf_top vrf_top_i
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr_en_0    (wr_en_v[0]),
      .wr_addr_0  (wr_addr_v[0]),
      .wr_mask_0  (wr_mask_v[0]),
      .wr_data_0  (wr_data_v[0]),
      .wr_en_1    (wr_en_v[1]),
      .wr_addr_1  (wr_addr_v[1]),
      .wr_mask_1  (wr_mask_v[1]),
      .wr_data_1  (wr_data_v[1]),
      .rd_en_0    (rd_en_v[0]),
      .rd_addr_0  (rd_addr_v[0]),
      .rd_en_1    (rd_en_v[1]),
      .rd_addr_1  (rd_addr_v[1]),
      .rd_en_2    (rd_en_v[2]),
      .rd_addr_2  (rd_addr_v[2]),
      .rd_en_3    (rd_en_v[3]),
      .rd_addr_3  (rd_addr_v[3]),
      .rd_valid_0 (rd_valid_v[0]),
      .rd_valid_1 (rd_valid_v[1]),
      .rd_valid_2 (rd_valid_v[2]),
      .rd_valid_3 (rd_valid_v[3]),
      .rd_data_0  (rd_data_v[0]),
      .rd_data_1  (rd_data_v[1]),
      .rd_data_2  (rd_data_v[2]),
      .rd_data_3  (rd_data_v[3])
   );

   task automatic check_elem(input string name, input int lane, input vrf_elem_t got,
                             input vrf_elem_t exp);
      if (got !== exp)
      begin
         $display("Error at %0t: %s lane %0d is %h, expected %h", $time, name, lane, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "read data mismatch");
      end
   endtask

   task automatic check_valid(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "read strobe mismatch");
      end
   endtask

   function automatic vrf_elem_t rand_elem();
      return vrf_elem_t'($random(seed));
   endfunction

   function automatic vrf_addr_t rand_addr();
      return vrf_addr_t'($random(seed));
   endfunction

   task automatic idle_inputs();
      for (int w = 0; w < `VRF_WPORTS; w++)
      begin
         wr_en_v[w]   = 1'b0;
         wr_addr_v[w] = '0;
         wr_mask_v[w] = '0;
         wr_data_v[w] = '0;
      end
      for (int r = 0; r < `VRF_RPORTS; r++)
      begin
         rd_en_v[r]   = 1'b0;
         rd_addr_v[r] = '0;
      end
   endtask

   task automatic set_write(input int w, input vrf_addr_t addr, input vrf_lane_mask_t mask);
      wr_en_v[w]   = 1'b1;
      wr_addr_v[w] = addr;
      wr_mask_v[w] = mask;
      for (int l = 0; l < `V_LANES; l++)
      begin
         wr_data_v[w][l] = rand_elem();
      end
   endtask

   task automatic read_all_ports(input vrf_addr_t addr);
      for (int r = 0; r < `VRF_RPORTS; r++)
      begin
         rd_en_v[r]   = 1'b1;
         rd_addr_v[r] = addr;
      end
   endtask

   // one clock: update the model, let the DUT take the inputs, compare
   task automatic step();
      // reads see the contents from before this cycle's writes
      for (int r = 0; r < `VRF_RPORTS; r++)
      begin
         exp_valid[r] = rd_en_v[r];
         for (int l = 0; l < `V_LANES; l++)
         begin
            exp_data[r][l] = model_mem[l][rd_addr_v[r]];
         end
      end
      // port 1 applied last, so it wins a collision
      for (int w = 0; w < `VRF_WPORTS; w++)
      begin
         for (int l = 0; l < `V_LANES; l++)
         begin
            if (wr_en_v[w] && wr_mask_v[w][l])
            begin
               model_mem[l][wr_addr_v[w]] = wr_data_v[w][l];
            end
         end
      end
      @(posedge clk);
      #1;
      for (int r = 0; r < `VRF_RPORTS; r++)
      begin
         check_valid($sformatf("rd_valid_%0d", r), rd_valid_v[r], exp_valid[r]);
         if (exp_valid[r])
         begin
            for (int l = 0; l < `V_LANES; l++)
            begin
               check_elem($sformatf("rd_data_%0d", r), l, rd_data_v[r][l], exp_data[r][l]);
            end
         end
      end
   endtask

   // single read on one port
   task automatic read_one_port(input int p, input vrf_addr_t addr);
      idle_inputs();
      rd_en_v[p]   = 1'b1;
      rd_addr_v[p] = addr;
      // strobe and data are due on the next edge
      step();
      idle_inputs();
      // strobe has to drop again on the next cycle
      step();
   endtask

   initial
   begin
      vrf_elem_t saved [`V_LANES];
      vrf_addr_t addr;

      seed  = 16871;
      rst_n = 1'b0;
      idle_inputs();
      for (int i = 0; i < 2; i++)
      begin
         @(posedge clk);
         #1;
         for (int r = 0; r < `VRF_RPORTS; r++)
         begin
            check_valid($sformatf("rd_valid_%0d", r), rd_valid_v[r], 1'b0);
         end
      end
      rst_n = 1'b1;
      step();

      // fill every address, two per cycle
      for (int a = 0; a < `VRF_DEPTH; a += 2)
      begin
         set_write(0, vrf_addr_t'(a), '1);
         set_write(1, vrf_addr_t'(a + 1), '1);
         step();
      end
      idle_inputs();

      for (int p = 0; p < `VRF_RPORTS; p++)
      begin
         read_one_port(p, rand_addr());
      end

      // write on either port, read back on all four
      for (int k = 0; k < 16; k++)
      begin
         idle_inputs();
         addr = rand_addr();
         set_write($random(seed) & 1, addr, '1);
         step();
         idle_inputs();
         read_all_ports(addr);
         step();
      end

      // same address on both write ports
      for (int k = 0; k < 8; k++)
      begin
         idle_inputs();
         addr = rand_addr();
         set_write(0, addr, '1);
         set_write(1, addr, '1);
         for (int l = 0; l < `V_LANES; l++)
         begin
            saved[l] = wr_data_v[1][l];
         end
         step();
         idle_inputs();
         read_all_ports(addr);
         step();
         for (int l = 0; l < `V_LANES; l++)
         begin
            check_elem("rd_data_0", l, rd_data_v[0][l], saved[l]);
         end
      end

      // read and write of one address in the same cycle
      for (int k = 0; k < 16; k++)
      begin
         idle_inputs();
         addr = rand_addr();
         set_write(k % 2, addr, '1);
         for (int l = 0; l < `V_LANES; l++)
         begin
            saved[l] = wr_data_v[k % 2][l];
         end
         read_all_ports(addr);
         step();
         idle_inputs();
         read_all_ports(addr);
         step();
         for (int l = 0; l < `V_LANES; l++)
         begin
            check_elem("rd_data_3", l, rd_data_v[3][l], saved[l]);
         end
      end

      // partial lane masks
      for (int k = 0; k < 16; k++)
      begin
         idle_inputs();
         addr = rand_addr();
         set_write($random(seed) & 1, addr, vrf_lane_mask_t'($random(seed)));
         step();
         idle_inputs();
         read_all_ports(addr);
         step();
      end

      // every port busy on every cycle
      for (int k = 0; k < MIX_CYCLES; k++)
      begin
         for (int w = 0; w < `VRF_WPORTS; w++)
         begin
            // small address window now and then, for collisions
            addr = ($random(seed) & 1) ? vrf_addr_t'($random(seed) & 7) : rand_addr();
            set_write(w, addr, vrf_lane_mask_t'($random(seed)));
         end
         for (int r = 0; r < `VRF_RPORTS; r++)
         begin
            rd_en_v[r]   = 1'b1;
            rd_addr_v[r] = ($random(seed) & 1) ? vrf_addr_t'($random(seed) & 7) : rand_addr();
         end
         step();
      end
      idle_inputs();
      step();

      $display("RESULT: PASS");
      $finish;
   end

   // stops a run whose clock or stimulus has stalled
   initial
   begin
      #(RUN_LIMIT_NS);
      $display("Timeout: simulation ran past its time limit");
      $display("RESULT: FAIL");
      $fatal(1, "run time limit reached");
   end

endmodule : vrf_tb

`default_nettype wire

//--- vrf.f
+incdir+.
vrf_pkg.sv
vrf_bank_ram.sv
vrf_lvt.sv
vrf_lane.sv
vrf_top.sv
vrf_props.sv
vrf_tb.sv

//--- Makefile
VERILATOR = verilator
TOP       = vrf_tb
FILELIST  = vrf.f
OBJ_DIR   = obj_dir
FLAGS     = --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
